// File: source/pinmux_cfg_pkg.sv
// Bit positions in the multi-function select word for the kept functions only.
// Unlisted bits of the word are ignored by the pad multiplexer.
`default_nettype none

package pinmux_cfg_pkg;

  // --------------------
  // Select word
  // --------------------

  // Width of the multi-function select word
  localparam int CFG_W = 32;

  // PWM output enables, one per channel
  localparam int PWM_LSB = 0;
  localparam int PWM_W   = 6;

  // External interrupt input enables
  localparam int INT_LSB = 6;
  localparam int INT_W   = 2;

  // UART 0 enable, bit 9 (UART 1) stays unused
  localparam int UART0_BIT = 8;

  // SPI master enable, takes SCK, SDO and SDI
  localparam int SPIM_BIT = 10;

  // --------------------
  // SPI chip selects
  // --------------------

  // Chip select enables
  // Bit 0 is chip select 0, bit 1 is chip select 1
  localparam int SPIM_CS_LSB = 11;
  localparam int SPIM_CS_W   = 2;

endpackage

`default_nettype wire

// File: source/pinmux_pad_pkg.sv
// Pad numbering is port B on pads 0 to 7 and port D on pads 8 to 15.
// Strap list length must match the strap width set at the top level.
`default_nettype none

package pinmux_pad_pkg;

  // --------------------
  // Pad numbering
  // --------------------

  localparam int PORT_W   = 8;
  localparam int NUM_PADS = 2 * PORT_W;

  // Port B
  localparam int PAD_B0      = 0;
  localparam int PAD_B1_SS1  = 1;
  localparam int PAD_B2_SS0  = 2;
  localparam int PAD_B3_MOSI = 3;
  localparam int PAD_B4_MISO = 4;
  localparam int PAD_B5_SCK  = 5;
  localparam int PAD_B6      = 6;
  localparam int PAD_B7      = 7;

  // Port D, placed above port B
  localparam int PAD_D0_RXD0 = PORT_W + 0;
  localparam int PAD_D1_TXD0 = PORT_W + 1;
  localparam int PAD_D2_INT0 = PORT_W + 2;
  localparam int PAD_D3_INT1 = PORT_W + 3;
  localparam int PAD_D4      = PORT_W + 4;
  localparam int PAD_D5      = PORT_W + 5;
  localparam int PAD_D6      = PORT_W + 6;
  localparam int PAD_D7      = PORT_W + 7;

  // Number of WS281x serial lines
  localparam int WS_W = 4;

  // --------------------
  // Straps
  // --------------------

  localparam int STRAP_W_DEF = 4;

  // Strap n is sampled from pad STRAP_PAD[n]
  // Pads chosen are outputs by default (TXD, SCK, chip selects)
  localparam int STRAP_PAD [STRAP_W_DEF] = '{
    PAD_D1_TXD0,
    PAD_B5_SCK,
    PAD_B2_SS0,
    PAD_B1_SS1
  };

  // Pad owner, eighteen values so five bits
  // WS and PWM entries must stay contiguous, the output mux indexes from WS0 and PWM0
  typedef enum logic [4:0] {
    NONE,
    GPIO,
    WS0, WS1, WS2, WS3,
    PWM0, PWM1, PWM2, PWM3, PWM4, PWM5,
    UART_TX,
    SPI_CS0,
    SPI_CS1,
    SPI_SCK,
    SPI_SDO,
    INPUT
  } pad_owner_t;

endpackage

`default_nettype wire

// File: source/pad_route_if.sv
// Routing decisions from the owner decoder, all driven by one module.
`timescale 1ns/1ps
`default_nettype none

interface pad_route_if;

  // Owner of each pad
  pinmux_pad_pkg::pad_owner_t owner [pinmux_pad_pkg::NUM_PADS];

  // Output enable, active low (1 means input)
  logic [pinmux_pad_pkg::NUM_PADS-1:0] pad_oen;

  // Input side selects
  logic                             uart_rx_sel;
  logic [pinmux_cfg_pkg::INT_W-1:0] int_sel;
  logic                             spim_sdi_sel;

  // Decoder writes everything
  modport decode (
    output owner, pad_oen, uart_rx_sel, int_sel, spim_sdi_sel
  );

  // Output mux side
  modport drive (input owner, pad_oen);

  // Input routing side
  modport route (input uart_rx_sel, int_sel, spim_sdi_sel);

endinterface

`default_nettype wire

// File: source/pad_owner_decode.sv
// Purely combinational owner table, reacts to config changes in the same cycle.
// Bit n of the direction and out-type words belongs to pad n.
`timescale 1ns/1ps
`default_nettype none

module pad_owner_decode (
  input  wire [pinmux_cfg_pkg::CFG_W-1:0]      cfg_multi_func_sel_i,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]   cfg_gpio_dir_sel_i,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]   cfg_gpio_out_type_i,
  input  wire                                  strap_pad_ctrl_i,
  pad_route_if.decode                          route
);

  // PWM channel n lands on PWM_PAD[n]
  localparam int PWM_PAD [pinmux_cfg_pkg::PWM_W] = '{
    pinmux_pad_pkg::PAD_D3_INT1,
    pinmux_pad_pkg::PAD_D5,
    pinmux_pad_pkg::PAD_D6,
    pinmux_pad_pkg::PAD_B1_SS1,
    pinmux_pad_pkg::PAD_B2_SS0,
    pinmux_pad_pkg::PAD_B3_MOSI
  };

  // Function enables out of the select word
  logic [pinmux_cfg_pkg::PWM_W-1:0]     pwm_en;
  logic [pinmux_cfg_pkg::INT_W-1:0]     int_en;
  logic                                 uart0_en;
  logic                                 spim_en;
  logic [pinmux_cfg_pkg::SPIM_CS_W-1:0] cs_en;

  assign pwm_en   = cfg_multi_func_sel_i[pinmux_cfg_pkg::PWM_LSB +: pinmux_cfg_pkg::PWM_W];
  assign int_en   = cfg_multi_func_sel_i[pinmux_cfg_pkg::INT_LSB +: pinmux_cfg_pkg::INT_W];
  assign uart0_en = cfg_multi_func_sel_i[pinmux_cfg_pkg::UART0_BIT];
  assign spim_en  = cfg_multi_func_sel_i[pinmux_cfg_pkg::SPIM_BIT];
  assign cs_en    =
    cfg_multi_func_sel_i[pinmux_cfg_pkg::SPIM_CS_LSB +: pinmux_cfg_pkg::SPIM_CS_W];

  // WS281x line wired to a pad, NONE where no line exists
  function automatic pinmux_pad_pkg::pad_owner_t ws_owner(input int pad);
    case (pad)
      pinmux_pad_pkg::PAD_D0_RXD0,
      pinmux_pad_pkg::PAD_D1_TXD0,
      pinmux_pad_pkg::PAD_D2_INT0:  return pinmux_pad_pkg::WS0;
      pinmux_pad_pkg::PAD_D3_INT1,
      pinmux_pad_pkg::PAD_D4,
      pinmux_pad_pkg::PAD_B6,
      pinmux_pad_pkg::PAD_B7:       return pinmux_pad_pkg::WS1;
      pinmux_pad_pkg::PAD_D5,
      pinmux_pad_pkg::PAD_D6,
      pinmux_pad_pkg::PAD_D7,
      pinmux_pad_pkg::PAD_B0:       return pinmux_pad_pkg::WS2;
      pinmux_pad_pkg::PAD_B1_SS1,
      pinmux_pad_pkg::PAD_B2_SS0,
      pinmux_pad_pkg::PAD_B3_MOSI,
      pinmux_pad_pkg::PAD_B4_MISO:  return pinmux_pad_pkg::WS3;
      // B5 (SCK) carries no WS line
      default:                      return pinmux_pad_pkg::NONE;
    endcase
  endfunction

  // --------------------
  // Owner table
  // --------------------
  // Written lowest priority first, a later hit overrides an earlier one
  always_comb begin
    // GPIO, then WS281x on top of it
    for (int p = 0; p < pinmux_pad_pkg::NUM_PADS; p++) begin
      route.owner[p] = pinmux_pad_pkg::NONE;
      if (cfg_gpio_dir_sel_i[p])
        route.owner[p] = pinmux_pad_pkg::GPIO;
      if (cfg_gpio_out_type_i[p] && ws_owner(p) != pinmux_pad_pkg::NONE)
        route.owner[p] = ws_owner(p);
    end

    // UART 0, RXD in on D0 and TXD out on D1
    if (uart0_en) begin
      route.owner[pinmux_pad_pkg::PAD_D0_RXD0] = pinmux_pad_pkg::INPUT;
      route.owner[pinmux_pad_pkg::PAD_D1_TXD0] = pinmux_pad_pkg::UART_TX;
    end

    // Interrupt inputs
    if (int_en[0])
      route.owner[pinmux_pad_pkg::PAD_D2_INT0] = pinmux_pad_pkg::INPUT;
    if (int_en[1])
      route.owner[pinmux_pad_pkg::PAD_D3_INT1] = pinmux_pad_pkg::INPUT;

    // SPI master data and clock
    if (spim_en) begin
      route.owner[pinmux_pad_pkg::PAD_B5_SCK]  = pinmux_pad_pkg::SPI_SCK;
      route.owner[pinmux_pad_pkg::PAD_B4_MISO] = pinmux_pad_pkg::SPI_SDO;
      route.owner[pinmux_pad_pkg::PAD_B3_MOSI] = pinmux_pad_pkg::INPUT;
    end

    // Chip selects beat UART and SPI data
    if (cs_en[1])
      route.owner[pinmux_pad_pkg::PAD_B1_SS1] = pinmux_pad_pkg::SPI_CS1;
    if (cs_en[0])
      route.owner[pinmux_pad_pkg::PAD_B2_SS0] = pinmux_pad_pkg::SPI_CS0;

    // PWM beats everything, also interrupt 1 on D3
    for (int i = 0; i < pinmux_cfg_pkg::PWM_W; i++) begin
      if (pwm_en[i])
        route.owner[PWM_PAD[i]] =
          pinmux_pad_pkg::pad_owner_t'(int'(pinmux_pad_pkg::PWM0) + i);
    end
  end

  // --------------------
  // Output enables
  // --------------------
  always_comb begin
    for (int p = 0; p < pinmux_pad_pkg::NUM_PADS; p++) begin
      route.pad_oen[p] = (route.owner[p] == pinmux_pad_pkg::NONE) ||
                         (route.owner[p] == pinmux_pad_pkg::INPUT);
    end
    // Strap control parks the strap pads as inputs, data mux untouched
    if (strap_pad_ctrl_i) begin
      for (int i = 0; i < pinmux_pad_pkg::STRAP_W_DEF; i++)
        route.pad_oen[pinmux_pad_pkg::STRAP_PAD[i]] = 1'b1;
    end
  end

  // Input selects follow the enables, not the owners
  // so interrupt 1 still sees D3 under PWM0
  assign route.uart_rx_sel  = uart0_en;
  assign route.int_sel      = int_en;
  assign route.spim_sdi_sel = spim_en;

endmodule

`default_nettype wire

// File: source/pad_in_route.sv
// Strap register loads on every clock while reset is high, then holds.
// STRAP_W above the package strap list length is not supported.
`timescale 1ns/1ps
`default_nettype none

module pad_in_route #(
  parameter int STRAP_W = pinmux_pad_pkg::STRAP_W_DEF
) (
  input  wire                                mclk,
  input  wire                                rst_i,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0] pad_in_i,
  pad_route_if.route                         route,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0] pad_gpio_in_o,
  output logic                               uart_rxd_o,
  output logic [pinmux_cfg_pkg::INT_W-1:0]   ext_intr_o,
  output logic                               spim_sdi_o,
  output logic [STRAP_W-1:0]                 strap_o
);

  // GPIO always sees the raw pad levels
  assign pad_gpio_in_o = pad_in_i;

  // --------------------
  // Peripheral inputs
  // --------------------

  // UART idles high when not selected
  assign uart_rxd_o = route.uart_rx_sel ? pad_in_i[pinmux_pad_pkg::PAD_D0_RXD0] : 1'b1;

  // Interrupts idle low
  assign ext_intr_o[0] = route.int_sel[0] & pad_in_i[pinmux_pad_pkg::PAD_D2_INT0];
  assign ext_intr_o[1] = route.int_sel[1] & pad_in_i[pinmux_pad_pkg::PAD_D3_INT1];

  // SPI read data on B3
  assign spim_sdi_o = route.spim_sdi_sel & pad_in_i[pinmux_pad_pkg::PAD_B3_MOSI];

  // --------------------
  // Strap capture
  // --------------------
  // Tracks the strap pads during reset, last sample kept afterwards
  always_ff @(posedge mclk) begin
    if (rst_i) begin
      for (int i = 0; i < STRAP_W; i++)
        strap_o[i] <= pad_in_i[pinmux_pad_pkg::STRAP_PAD[i]];
    end
  end

endmodule

`default_nettype wire

// File: source/pad_out_drive.sv
// Output data mux, unowned and input pads drive 0.
`timescale 1ns/1ps
`default_nettype none

module pad_out_drive (
  pad_route_if.drive                            route,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]    pad_gpio_out_i,
  input  wire [pinmux_pad_pkg::WS_W-1:0]        ws_txd_i,
  input  wire [pinmux_cfg_pkg::PWM_W-1:0]       pwm_wfm_i,
  input  wire                                   uart_txd_i,
  input  wire                                   spim_sck_i,
  input  wire [pinmux_cfg_pkg::SPIM_CS_W-1:0]   spim_ssn_i,
  input  wire                                   spim_sdo_i,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0]   pad_out_o,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0]   pad_oen_o
);

  // --------------------
  // Data mux
  // --------------------
  always_comb begin
    for (int p = 0; p < pinmux_pad_pkg::NUM_PADS; p++) begin
      case (route.owner[p])
        pinmux_pad_pkg::GPIO:
          pad_out_o[p] = pad_gpio_out_i[p];
        // WS line number is the offset from WS0
        pinmux_pad_pkg::WS0, pinmux_pad_pkg::WS1,
        pinmux_pad_pkg::WS2, pinmux_pad_pkg::WS3:
          pad_out_o[p] = ws_txd_i[int'(route.owner[p]) - int'(pinmux_pad_pkg::WS0)];
        // Same trick for the PWM channel
        pinmux_pad_pkg::PWM0, pinmux_pad_pkg::PWM1, pinmux_pad_pkg::PWM2,
        pinmux_pad_pkg::PWM3, pinmux_pad_pkg::PWM4, pinmux_pad_pkg::PWM5:
          pad_out_o[p] = pwm_wfm_i[int'(route.owner[p]) - int'(pinmux_pad_pkg::PWM0)];
        pinmux_pad_pkg::UART_TX:
          pad_out_o[p] = uart_txd_i;
        pinmux_pad_pkg::SPI_CS0:
          pad_out_o[p] = spim_ssn_i[0];
        pinmux_pad_pkg::SPI_CS1:
          pad_out_o[p] = spim_ssn_i[1];
        pinmux_pad_pkg::SPI_SCK:
          pad_out_o[p] = spim_sck_i;
        pinmux_pad_pkg::SPI_SDO:
          pad_out_o[p] = spim_sdo_i;
        // NONE and INPUT
        default:
          pad_out_o[p] = 1'b0;
      endcase
    end
  end

  // Enables come ready-made from the decoder
  assign pad_oen_o = route.pad_oen;

endmodule

`default_nettype wire

// File: source/pinmux_top.sv
// Pad multiplexer for ports B and D, combinational except the strap register.
// pad_oen_o is active low; config words are indexed by pad number.
`timescale 1ns/1ps
`default_nettype none

module pinmux_top #(
  parameter int STRAP_W = pinmux_pad_pkg::STRAP_W_DEF
) (
  input  wire                                   mclk,
  input  wire                                   rst_i,
  input  wire                                   strap_pad_ctrl_i,

  // Configuration
  input  wire [pinmux_cfg_pkg::CFG_W-1:0]       cfg_multi_func_sel_i,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]    cfg_gpio_dir_sel_i,
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]    cfg_gpio_out_type_i,

  // Pads
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]    pad_in_i,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0]   pad_out_o,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0]   pad_oen_o,

  // GPIO
  input  wire [pinmux_pad_pkg::NUM_PADS-1:0]    pad_gpio_out_i,
  output logic [pinmux_pad_pkg::NUM_PADS-1:0]   pad_gpio_in_o,

  // WS281x and PWM
  input  wire [pinmux_pad_pkg::WS_W-1:0]        ws_txd_i,
  input  wire [pinmux_cfg_pkg::PWM_W-1:0]       pwm_wfm_i,

  // UART 0 and interrupts
  input  wire                                   uart_txd_i,
  output logic                                  uart_rxd_o,
  output logic [pinmux_cfg_pkg::INT_W-1:0]      ext_intr_o,

  // SPI master
  input  wire                                   spim_sck_i,
  input  wire [pinmux_cfg_pkg::SPIM_CS_W-1:0]   spim_ssn_i,
  input  wire                                   spim_sdo_i,
  output logic                                  spim_sdi_o,

  // Strap values sampled in reset
  output logic [STRAP_W-1:0]                    strap_o
);

  // Per-pad routing between decoder and the two mux halves
  pad_route_if i_route_if ();

  // --------------------
  // Owner decode
  // --------------------
  pad_owner_decode i_owner_decode (
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .strap_pad_ctrl_i     (strap_pad_ctrl_i),
    .route                (i_route_if.decode)
  );

  // Input side, straps live here
  pad_in_route #(
    .STRAP_W (STRAP_W)
  ) i_in_route (
    .mclk          (mclk),
    .rst_i         (rst_i),
    .pad_in_i      (pad_in_i),
    .route         (i_route_if.route),
    .pad_gpio_in_o (pad_gpio_in_o),
    .uart_rxd_o    (uart_rxd_o),
    .ext_intr_o    (ext_intr_o),
    .spim_sdi_o    (spim_sdi_o),
    .strap_o       (strap_o)
  );

  // Output side
  pad_out_drive i_out_drive (
    .route          (i_route_if.drive),
    .pad_gpio_out_i (pad_gpio_out_i),
    .ws_txd_i       (ws_txd_i),
    .pwm_wfm_i      (pwm_wfm_i),
    .uart_txd_i     (uart_txd_i),
    .spim_sck_i     (spim_sck_i),
    .spim_ssn_i     (spim_ssn_i),
    .spim_sdo_i     (spim_sdo_i),
    .pad_out_o      (pad_out_o),
    .pad_oen_o      (pad_oen_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_pinmux.sv
// Reads strap vector and steps from sim/pinmux_tests.txt, run from the project root.
// One step per clock, outputs checked on the following rising edge.
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux;

  localparam int NUM_PADS  = pinmux_pad_pkg::NUM_PADS;
  localparam int STRAP_W   = pinmux_pad_pkg::STRAP_W_DEF;
  localparam int MAX_STEPS = 64;
  localparam int NUM_COLS  = 18;
  localparam string TEST_FILE = "sim/pinmux_tests.txt";

  // Column order of a step line, inputs first then expected outputs
  localparam int COL_CFG  = 0;
  localparam int COL_DIR  = 1;
  localparam int COL_OTYP = 2;
  localparam int COL_SCTL = 3;
  localparam int COL_PIN  = 4;
  localparam int COL_GOUT = 5;
  localparam int COL_WS   = 6;
  localparam int COL_PWM  = 7;
  localparam int COL_UTX  = 8;
  localparam int COL_SCK  = 9;
  localparam int COL_SSN  = 10;
  localparam int COL_SDO  = 11;
  localparam int COL_OUT  = 12;
  localparam int COL_OEN  = 13;
  localparam int COL_GIN  = 14;
  localparam int COL_RXD  = 15;
  localparam int COL_INT  = 16;
  localparam int COL_SDI  = 17;

  // Strap n sits on this pad (D1, B5, B2, B1)
  localparam int STRAP_PADS [STRAP_W] = '{
    pinmux_pad_pkg::PAD_D1_TXD0,
    pinmux_pad_pkg::PAD_B5_SCK,
    pinmux_pad_pkg::PAD_B2_SS0,
    pinmux_pad_pkg::PAD_B1_SS1
  };

  // DUT inputs
  logic                mclk;
  logic                rst_i;
  logic                strap_pad_ctrl_i;
  logic [31:0]         cfg_multi_func_sel_i;
  logic [NUM_PADS-1:0] cfg_gpio_dir_sel_i;
  logic [NUM_PADS-1:0] cfg_gpio_out_type_i;
  logic [NUM_PADS-1:0] pad_in_i;
  logic [NUM_PADS-1:0] pad_gpio_out_i;
  logic [3:0]          ws_txd_i;
  logic [5:0]          pwm_wfm_i;
  logic                uart_txd_i;
  logic                spim_sck_i;
  logic [1:0]          spim_ssn_i;
  logic                spim_sdo_i;

  // DUT outputs
  logic [NUM_PADS-1:0] pad_out_o;
  logic [NUM_PADS-1:0] pad_oen_o;
  logic [NUM_PADS-1:0] pad_gpio_in_o;
  logic                uart_rxd_o;
  logic [1:0]          ext_intr_o;
  logic                spim_sdi_o;
  logic [STRAP_W-1:0]  strap_o;

  // Loaded vectors and run state
  logic [31:0]        vec [MAX_STEPS][NUM_COLS];
  int                 num_steps;
  logic [STRAP_W-1:0] strap_vec;
  int                 error_count;
  int                 check_count;
  int                 cycle_limit;
  int                 cycle_count = 0;

  pinmux_top #(
    .STRAP_W (STRAP_W)
  ) i_pinmux_top (
    .mclk                 (mclk),
    .rst_i                (rst_i),
    .strap_pad_ctrl_i     (strap_pad_ctrl_i),
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .pad_in_i             (pad_in_i),
    .pad_out_o            (pad_out_o),
    .pad_oen_o            (pad_oen_o),
    .pad_gpio_out_i       (pad_gpio_out_i),
    .pad_gpio_in_o        (pad_gpio_in_o),
    .ws_txd_i             (ws_txd_i),
    .pwm_wfm_i            (pwm_wfm_i),
    .uart_txd_i           (uart_txd_i),
    .uart_rxd_o           (uart_rxd_o),
    .ext_intr_o           (ext_intr_o),
    .spim_sck_i           (spim_sck_i),
    .spim_ssn_i           (spim_ssn_i),
    .spim_sdo_i           (spim_sdo_i),
    .spim_sdi_o           (spim_sdi_o),
    .strap_o              (strap_o)
  );

  // 100 ns clock
  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;
  end

  // --------------------
  // Watchdog
  // --------------------
  always @(posedge mclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout, no result after %0d cycles", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  // Comment lines start with #, blank lines skipped
  function automatic bit is_data_line(string line);
    logic [7:0] c;
    if (line.len() == 0)
      return 1'b0;
    c = line.getc(0);
    return !(c == "#" || c == "\n" || c == "\r");
  endfunction

  // Pad levels that present a strap vector on the strap pads
  function automatic logic [NUM_PADS-1:0] strap_pads(logic [STRAP_W-1:0] v);
    logic [NUM_PADS-1:0] p;
    p = '0;
    for (int i = 0; i < STRAP_W; i++)
      p[STRAP_PADS[i]] = v[i];
    return p;
  endfunction

  // --------------------
  // Vector file
  // --------------------
  task automatic load_tests(output bit ok);
    int          fd;
    int          code;
    int          n;
    bit          good;
    bit          have_strap;
    string       line;
    logic [31:0] sv;
    logic [31:0] f [NUM_COLS];
    good       = 1'b1;
    have_strap = 1'b0;
    num_steps  = 0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test vector file %s", TEST_FILE);
      good = 1'b0;
    end else begin
      while (good && !$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && is_data_line(line)) begin
          if (!have_strap) begin
            // First data line is the strap vector
            n = $sscanf(line, "%h", sv);
            if (n != 1) begin
              $display("strap line in %s could not be read", TEST_FILE);
              good = 1'b0;
            end else begin
              strap_vec  = sv[STRAP_W-1:0];
              have_strap = 1'b1;
            end
          end else if (num_steps >= MAX_STEPS) begin
            $display("more than %0d steps in %s", MAX_STEPS, TEST_FILE);
            good = 1'b0;
          end else begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (n != NUM_COLS) begin
              $display("step %0d in %s has %0d columns instead of %0d",
                       num_steps, TEST_FILE, n, NUM_COLS);
              good = 1'b0;
            end else begin
              for (int c = 0; c < NUM_COLS; c++)
                vec[num_steps][c] = f[c];
              num_steps++;
            end
          end
        end
      end
      $fclose(fd);
      if (good && num_steps == 0) begin
        $display("no test steps found in %s", TEST_FILE);
        good = 1'b0;
      end
    end
    ok = good;
  endtask

  // Drive one step, called right on a rising edge
  task automatic apply_step(int s);
    cfg_multi_func_sel_i <= vec[s][COL_CFG];
    cfg_gpio_dir_sel_i   <= vec[s][COL_DIR][NUM_PADS-1:0];
    cfg_gpio_out_type_i  <= vec[s][COL_OTYP][NUM_PADS-1:0];
    strap_pad_ctrl_i     <= vec[s][COL_SCTL][0];
    pad_in_i             <= vec[s][COL_PIN][NUM_PADS-1:0];
    pad_gpio_out_i       <= vec[s][COL_GOUT][NUM_PADS-1:0];
    ws_txd_i             <= vec[s][COL_WS][3:0];
    pwm_wfm_i            <= vec[s][COL_PWM][5:0];
    uart_txd_i           <= vec[s][COL_UTX][0];
    spim_sck_i           <= vec[s][COL_SCK][0];
    spim_ssn_i           <= vec[s][COL_SSN][1:0];
    spim_sdo_i           <= vec[s][COL_SDO][0];
  endtask

  task automatic report_mismatch(int s, string name, logic [31:0] got, logic [31:0] exp);
    error_count++;
    $display("mismatch at %0d ns, step %0d, %s: got %0h, expected %0h",
             $time, s, name, got, exp);
  endtask

  // Expected values come straight from the file
  task automatic check_step(int s);
    check_count += 7;
    if (pad_out_o !== vec[s][COL_OUT][NUM_PADS-1:0])
      report_mismatch(s, "pad_out_o", 32'(pad_out_o), vec[s][COL_OUT]);
    if (pad_oen_o !== vec[s][COL_OEN][NUM_PADS-1:0])
      report_mismatch(s, "pad_oen_o", 32'(pad_oen_o), vec[s][COL_OEN]);
    if (pad_gpio_in_o !== vec[s][COL_GIN][NUM_PADS-1:0])
      report_mismatch(s, "pad_gpio_in_o", 32'(pad_gpio_in_o), vec[s][COL_GIN]);
    if (uart_rxd_o !== vec[s][COL_RXD][0])
      report_mismatch(s, "uart_rxd_o", 32'(uart_rxd_o), vec[s][COL_RXD]);
    if (ext_intr_o !== vec[s][COL_INT][1:0])
      report_mismatch(s, "ext_intr_o", 32'(ext_intr_o), vec[s][COL_INT]);
    if (spim_sdi_o !== vec[s][COL_SDI][0])
      report_mismatch(s, "spim_sdi_o", 32'(spim_sdi_o), vec[s][COL_SDI]);
    // Straps must hold whatever the pads do now
    if (strap_o !== strap_vec)
      report_mismatch(s, "strap_o", 32'(strap_o), 32'(strap_vec));
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    bit loaded;
    error_count = 0;
    check_count = 0;
    cycle_limit = 0;
    rst_i                <= 1'b1;
    strap_pad_ctrl_i     <= 1'b0;
    cfg_multi_func_sel_i <= '0;
    cfg_gpio_dir_sel_i   <= '0;
    cfg_gpio_out_type_i  <= '0;
    pad_in_i             <= '0;
    pad_gpio_out_i       <= '0;
    ws_txd_i             <= '0;
    pwm_wfm_i            <= '0;
    uart_txd_i           <= 1'b0;
    spim_sck_i           <= 1'b0;
    spim_ssn_i           <= '0;
    spim_sdo_i           <= 1'b0;
    load_tests(loaded);
    if (!loaded) begin
      error_count++;
      finish_run();
    end else begin
      // Reset, strap line, step lines, plus margin
      cycle_limit = 10 + 4 * (num_steps + 1) + 20;
      pad_in_i <= strap_pads(strap_vec);
      repeat (10) @(posedge mclk);
      rst_i <= 1'b0;
      @(posedge mclk);
      check_count++;
      if (strap_o !== strap_vec)
        report_mismatch(-1, "strap_o", 32'(strap_o), 32'(strap_vec));
      for (int s = 0; s < num_steps; s++) begin
        apply_step(s);
        @(posedge mclk);
        check_step(s);
      end
      finish_run();
    end
  end

endmodule

`default_nettype wire

// File: sim/pinmux_tests.txt
# First data line: strap vector, bit n is strap n (D1, B5, B2, B1). Then one step per line:
# cfg dir otype sctl pad_in gpio_out ws pwm utx sck ssn sdo  exp: out oen gpio_in rxd int sdi
9
# Idle, then GPIO only
0000 0000 0000 0 0000 0000 0 00 0 0 0 0  0000 ffff 0000 1 0 0
0000 ffff 0000 0 0c08 a5c3 0 00 0 0 0 0  a5c3 0000 0c08 1 0 0
0000 00ff 0000 0 f00f ffff 0 00 0 0 0 0  00ff ff00 f00f 1 0 0
# WS281x lines, B5 has none
0000 0000 ffff 0 0000 ffff 5 00 0 0 0 0  e701 0020 0000 1 0 0
0000 ffff 00f0 0 0000 ffff 5 00 0 0 0 0  ff2f 0000 0000 1 0 0
# PWM alone and over WS and GPIO
003f 0000 0000 0 0000 0000 0 15 0 0 0 0  4804 97f1 0000 1 0 0
003f ffff ffff 0 0000 0000 f 00 0 0 0 0  97d1 0000 0000 1 0 0
# Chip selects, then PWM3 and PWM4 over them
1800 0000 0000 0 0000 0000 0 00 0 0 2 0  0002 fff9 0000 1 0 0
1818 0000 0000 0 0000 0000 0 08 0 0 3 0  0002 fff9 0000 1 0 0
# UART 0
0100 0000 0000 0 0000 0000 0 00 1 0 0 0  0200 fdff 0000 0 0 0
0100 ffff ffff 0 0100 ffff f 00 0 0 0 0  fcff 0100 0100 1 0 0
# Interrupts, PWM0 keeps D3 while interrupt 1 still sees it
00c0 0000 0000 0 0c00 0000 0 00 0 0 0 0  0000 ffff 0c00 1 3 0
0040 ffff 0000 0 0c00 ffff 0 00 0 0 0 0  fbff 0400 0c00 1 1 0
0081 0000 0000 0 0800 0000 0 01 0 0 0 0  0800 f7ff 0800 1 2 0
# SPI master, PWM5 over SDI pad
0400 0000 0000 0 0008 0000 0 00 0 1 0 0  0020 ffcf 0008 1 0 1
0400 ffff 0000 0 0000 0000 0 00 0 0 0 1  0010 0008 0000 1 0 0
0420 0000 0000 0 0008 0000 0 20 0 0 0 0  0008 ffc7 0008 1 0 1
# Strap control, strap pads toggled against the captured vector
0000 ffff 0000 1 0024 ffff 0 00 0 0 0 0  ffff 0226 0024 1 0 0
1d00 0000 0000 1 0000 0000 0 00 1 1 3 1  0236 ffef 0000 0 0 0
1d00 0000 0000 0 0108 0000 0 00 1 1 3 1  0236 fdc9 0108 1 0 1
0000 0000 0000 0 0000 0000 0 00 0 0 0 0  0000 ffff 0000 1 0 0

// File: files.f
source/pinmux_cfg_pkg.sv
source/pinmux_pad_pkg.sv
source/pad_route_if.sv
source/pad_owner_decode.sv
source/pad_in_route.sv
source/pad_out_drive.sv
source/pinmux_top.sv
sim/tb_pinmux.sv

// File: run_sim.sh
#!/bin/sh
# Build the pad multiplexer testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_pinmux \
  -Mdir obj_dir -o tb_pinmux -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_pinmux > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  echo "failures reported, see $log"
  exit 1
fi

echo "no failures reported in $log"
exit 0
